//--- src.f
+incdir+design
design/dcache_pkg.sv
design/dcache_ram.sv
design/dcache_way.sv
design/dcache_write_ctrl.sv
design/dcache_lookup.sv
design/dcache_top.sv
test/dcache_props.sv
test/dcache_checker.sv
test/dcache_tb.sv

//--- test/dcache_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb;

    import dcache_pkg::*;

    localparam int NUM_ACCESSES = 2000;
    localparam int TIMEOUT_CYCLES = 2 * NUM_ACCESSES + 200;

    logic                      clk;
    logic                      rst;
    logic                      action;
    cache_addr_u               ad;
    cache_addr_u               pa;
    logic [`DC_OP_WIDTH-1:0]   op;
    logic [`DC_DATA_WIDTH-1:0] store_data;
    logic [`DC_BYTE_LANES-1:0] byte_en;
    logic [`DC_LINE_WIDTH-1:0] refill_data;
    logic                      select_way;
    logic                      lru_we;
    logic [`DC_DATA_WIDTH-1:0] load_data;
    logic                      hit;
    logic [`DC_LINE_WIDTH-1:0] victim_line;
    logic                      victim_valid;
    logic                      victim_dirty;
    logic                      lru_way;
    int                        error_count;
    int                        access_count;
    int                        cycle_count;
    int                        total_errors;
    logic [31:0]               rng;

    dcache_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .ad           (ad),
        .pa           (pa),
        .op           (op),
        .store_data   (store_data),
        .byte_en      (byte_en),
        .refill_data  (refill_data),
        .select_way   (select_way),
        .lru_we       (lru_we),
        .load_data    (load_data),
        .hit          (hit),
        .victim_line  (victim_line),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .lru_way      (lru_way)
    );

    dcache_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .action       (action),
        .pa           (pa),
        .op           (op),
        .store_data   (store_data),
        .byte_en      (byte_en),
        .refill_data  (refill_data),
        .select_way   (select_way),
        .lru_we       (lru_we),
        .load_data    (load_data),
        .hit          (hit),
        .victim_line  (victim_line),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .lru_way      (lru_way),
        .error_count  (error_count),
        .access_count (access_count)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Four tags and eight sets keep hits and conflicts frequent.
    task automatic run_access();
        logic [31:0] r;
        cache_addr_u a;
        rng = xorshift32(rng);
        r = rng;
        a.fields.tag = {18'h25a3c, r[1:0]};
        a.fields.index = {r[4:2], 4'h9};
        a.fields.word_sel = r[7:5];
        a.fields.byte_sel = r[9:8];

        @(negedge clk);
        ad = a;
        pa = a;
        op = `DC_OP_IDLE;
        lru_we = 1'b0;
        action = 1'b0;

        @(negedge clk);
        case (r[12:10])
            3'd0: op = `DC_OP_IDLE;
            3'd1, 3'd2, 3'd3: op = `DC_OP_LOAD;
            3'd4, 3'd5: op = `DC_OP_STORE;
            default: op = `DC_OP_REFILL;
        endcase
        byte_en = r[16:13];
        select_way = r[17];
        lru_we = r[18] | r[19];
        // Refilling a tag already held goes back into its own way.
        if (op == `DC_OP_REFILL) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (u_checker.model_valid[a.fields.index][w] &&
                    u_checker.model_tag[a.fields.index][w] == a.fields.tag) begin
                    select_way = w[0];
                end
            end
        end
        rng = xorshift32(rng);
        store_data = rng;
        for (int k = 0; k < `DC_WORDS; k++) begin
            rng = xorshift32(rng);
            refill_data[k*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] = rng;
        end
        action = 1'b1;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        action = 1'b0;
        ad = '0;
        pa = '0;
        op = `DC_OP_IDLE;
        store_data = '0;
        byte_en = '0;
        refill_data = '0;
        select_way = 1'b0;
        lru_we = 1'b0;
        cycle_count = 0;
        rng = 32'h415e_769c;

        repeat (3) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < NUM_ACCESSES; i++) begin
            run_access();
        end
        @(negedge clk);
        action = 1'b0;
        op = `DC_OP_IDLE;
        lru_we = 1'b0;
        @(negedge clk);

        total_errors = error_count + u_dut.u_props.assert_fails;
        if (access_count != NUM_ACCESSES) begin
            $display("Checker compared %0d accesses instead of %0d", access_count,
                     NUM_ACCESSES);
            total_errors++;
        end
        $display("Accesses: %0d, checker errors: %0d, assertion failures: %0d",
                 access_count, error_count, u_dut.u_props.assert_fails);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/dcache_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      action,
    input  dcache_pkg::cache_addr_u   pa,
    input  logic [`DC_OP_WIDTH-1:0]   op,
    input  logic [`DC_DATA_WIDTH-1:0] store_data,
    input  logic [`DC_BYTE_LANES-1:0] byte_en,
    input  logic [`DC_LINE_WIDTH-1:0] refill_data,
    input  logic                      select_way,
    input  logic                      lru_we,
    input  logic [`DC_DATA_WIDTH-1:0] load_data,
    input  logic                      hit,
    input  logic [`DC_LINE_WIDTH-1:0] victim_line,
    input  logic                      victim_valid,
    input  logic                      victim_dirty,
    input  logic                      lru_way,
    output int                        error_count,
    output int                        access_count
);

    import dcache_pkg::*;

    logic                      model_valid [`DC_SETS][`DC_WAYS];
    logic                      model_dirty [`DC_SETS][`DC_WAYS];
    logic                      model_known [`DC_SETS][`DC_WAYS];
    logic [`DC_TAG_WIDTH-1:0]  model_tag [`DC_SETS][`DC_WAYS];
    logic [`DC_DATA_WIDTH-1:0] model_data [`DC_SETS][`DC_WAYS][`DC_WORDS];
    logic                      model_lru [`DC_SETS];

    initial begin
        error_count = 0;
        access_count = 0;
    end

    task automatic compare(input string name, input logic [`DC_LINE_WIDTH-1:0] expected,
                           input logic [`DC_LINE_WIDTH-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error at %0t ns: %s expected %0h, actual %0h", $time, name, expected,
                     actual);
        end
    endtask

    // Run in the action cycle, before the edge applies its writes.
    task automatic check_and_update();
        cache_addr_u                 a;
        logic [`DC_INDEX_WIDTH-1:0]  idx;
        logic [`DC_WAYS-1:0]         exp_hit;
        logic [`DC_LINE_WIDTH-1:0]   exp_line;
        logic [`DC_DATA_WIDTH-1:0]   word;
        a = pa;
        idx = a.fields.index;
        for (int w = 0; w < `DC_WAYS; w++) begin
            exp_hit[w] = model_valid[idx][w] && (model_tag[idx][w] == a.fields.tag);
        end
        access_count++;
        compare("hit", |exp_hit, hit);
        if (exp_hit[0]) begin
            compare("load_data", model_data[idx][0][a.fields.word_sel], load_data);
        end else if (exp_hit[1]) begin
            compare("load_data", model_data[idx][1][a.fields.word_sel], load_data);
        end else if (model_known[idx][0]) begin
            compare("load_data", model_data[idx][0][0], load_data);
        end
        compare("victim_valid", model_valid[idx][select_way], victim_valid);
        compare("victim_dirty", model_dirty[idx][select_way], victim_dirty);
        if (model_known[idx][select_way]) begin
            for (int k = 0; k < `DC_WORDS; k++) begin
                exp_line[k*`DC_DATA_WIDTH +: `DC_DATA_WIDTH] = model_data[idx][select_way][k];
            end
            compare("victim_line", exp_line, victim_line);
        end
        compare("lru_way", model_lru[idx], lru_way);

        if (op == `DC_OP_STORE && |exp_hit) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                if (exp_hit[w]) begin
                    word = model_data[idx][w][a.fields.word_sel];
                    for (int l = 0; l < `DC_BYTE_LANES; l++) begin
                        if (byte_en[l]) begin
                            word[l*8 +: 8] = store_data[l*8 +: 8];
                        end
                    end
                    model_data[idx][w][a.fields.word_sel] = word;
                    model_dirty[idx][w] = 1'b1;
                end
            end
        end else if (op == `DC_OP_REFILL) begin
            for (int k = 0; k < `DC_WORDS; k++) begin
                model_data[idx][select_way][k] = refill_data[k*`DC_DATA_WIDTH +: `DC_DATA_WIDTH];
            end
            model_tag[idx][select_way] = a.fields.tag;
            model_valid[idx][select_way] = 1'b1;
            model_dirty[idx][select_way] = 1'b0;
            model_known[idx][select_way] = 1'b1;
        end
        // A miss records way 0.
        if (lru_we) begin
            model_lru[idx] = exp_hit[1];
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                model_lru[s] = 1'b0;
                for (int w = 0; w < `DC_WAYS; w++) begin
                    model_valid[s][w] = 1'b0;
                    model_dirty[s][w] = 1'b0;
                    model_known[s][w] = 1'b0;
                end
            end
        end else if (action) begin
            check_and_update();
        end
    end

endmodule

`default_nettype wire

//--- test/dcache_props.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_props (
    input  logic                                                   clk,
    input  logic                                                   rst,
    input  logic [`DC_OP_WIDTH-1:0]                                op,
    input  logic [`DC_WAYS-1:0]                                    way_hit,
    input  logic [`DC_WAYS-1:0][`DC_WORDS-1:0][`DC_BYTE_LANES-1:0] word_we,
    input  logic [`DC_WAYS-1:0]                                    tag_we,
    input  logic [`DC_WAYS-1:0]                                    valid_we,
    input  logic [`DC_WAYS-1:0]                                    dirty_we
);

    int assert_fails = 0;

    logic [`DC_WAYS-1:0] way_word_we;

    assign way_word_we = {|word_we[1], |word_we[0]};

    // A tag may live in only one way of a set.
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        way_hit != 2'b11)
    else begin
        assert_fails++;
        $error("way_hit shows both ways at once");
    end

    a_word_we_op: assert property (@(posedge clk) disable iff (rst)
        (|word_we) |-> (op == `DC_OP_STORE || op == `DC_OP_REFILL))
    else begin
        assert_fails++;
        $error("word write enable active outside store or refill");
    end

    a_refill_one_way: assert property (@(posedge clk) disable iff (rst)
        (op == `DC_OP_REFILL) |-> ($onehot(way_word_we) && $onehot(tag_we) &&
                                   $onehot(valid_we) && $onehot(dirty_we)))
    else begin
        assert_fails++;
        $error("refill write enables not confined to one way");
    end

endmodule

bind dcache_top dcache_props u_props (
    .clk      (clk),
    .rst      (rst),
    .op       (op),
    .way_hit  (way_hit),
    .word_we  (word_we),
    .tag_we   (tag_we),
    .valid_we (valid_we),
    .dirty_we (dirty_we)
);

`default_nettype wire

//--- design/dcache_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_pkg::cache_addr_u   ad,
    input  dcache_pkg::cache_addr_u   pa,
    input  logic [`DC_OP_WIDTH-1:0]   op,
    input  logic [`DC_DATA_WIDTH-1:0] store_data,
    input  logic [`DC_BYTE_LANES-1:0] byte_en,
    input  logic [`DC_LINE_WIDTH-1:0] refill_data,
    input  logic                      select_way,
    input  logic                      lru_we,
    output logic [`DC_DATA_WIDTH-1:0] load_data,
    output logic                      hit,
    output logic [`DC_LINE_WIDTH-1:0] victim_line,
    output logic                      victim_valid,
    output logic                      victim_dirty,
    output logic                      lru_way
);

    import dcache_pkg::*;

    logic [`DC_WAYS-1:0][`DC_WORDS-1:0][`DC_BYTE_LANES-1:0] word_we;
    logic [`DC_LINE_WIDTH-1:0]                              line_wdata;
    logic [`DC_WAYS-1:0]                                    tag_we;
    logic [`DC_WAYS-1:0]                                    valid_we;
    logic [`DC_WAYS-1:0]                                    dirty_we;
    logic [`DC_TAG_WIDTH-1:0]                               tag_wdata;
    logic                                                   valid_wdata;
    logic                                                   dirty_wdata;
    logic [`DC_WAYS-1:0][`DC_LINE_WIDTH-1:0]                rline;
    logic [`DC_WAYS-1:0][`DC_TAG_WIDTH-1:0]                 rtag;
    logic [`DC_WAYS-1:0]                                    rvalid;
    logic [`DC_WAYS-1:0]                                    rdirty;
    logic [`DC_WAYS-1:0]                                    way_hit;

    // Both ports of each way use the lookup address.
    for (genvar w = 0; w < `DC_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk         (clk),
            .rst         (rst),
            .raddr       (ad),
            .waddr       (ad),
            .word_we     (word_we[w]),
            .wdata       (line_wdata),
            .tag_we      (tag_we[w]),
            .tag_wdata   (tag_wdata),
            .valid_we    (valid_we[w]),
            .valid_wdata (valid_wdata),
            .dirty_we    (dirty_we[w]),
            .dirty_wdata (dirty_wdata),
            .rline       (rline[w]),
            .rtag        (rtag[w]),
            .rvalid      (rvalid[w]),
            .rdirty      (rdirty[w])
        );
    end

    dcache_write_ctrl u_write_ctrl (
        .op          (op),
        .ad          (ad),
        .byte_en     (byte_en),
        .store_data  (store_data),
        .refill_data (refill_data),
        .select_way  (select_way),
        .way_hit     (way_hit),
        .word_we     (word_we),
        .line_wdata  (line_wdata),
        .tag_we      (tag_we),
        .valid_we    (valid_we),
        .dirty_we    (dirty_we),
        .tag_wdata   (tag_wdata),
        .valid_wdata (valid_wdata),
        .dirty_wdata (dirty_wdata)
    );

    dcache_lookup u_lookup (
        .pa           (pa),
        .select_way   (select_way),
        .rline        (rline),
        .rtag         (rtag),
        .rvalid       (rvalid),
        .rdirty       (rdirty),
        .way_hit      (way_hit),
        .hit          (hit),
        .load_data    (load_data),
        .victim_line  (victim_line),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty)
    );

    // Replacement bit records the way that last hit in the set.
    dcache_ram #(
        .WIDTH (1),
        .DEPTH (`DC_SETS),
        .LANES (1),
        .CLEAR (1'b1)
    ) u_lru (
        .clk   (clk),
        .rst   (rst),
        .we    (lru_we),
        .waddr (pa.fields.index),
        .wdata (way_hit[1]),
        .raddr (ad.fields.index),
        .rdata (lru_way)
    );

endmodule

`default_nettype wire

//--- design/dcache_lookup.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_lookup (
    input  dcache_pkg::cache_addr_u                  pa,
    input  logic                                     select_way,
    input  logic [`DC_WAYS-1:0][`DC_LINE_WIDTH-1:0]  rline,
    input  logic [`DC_WAYS-1:0][`DC_TAG_WIDTH-1:0]   rtag,
    input  logic [`DC_WAYS-1:0]                      rvalid,
    input  logic [`DC_WAYS-1:0]                      rdirty,
    output logic [`DC_WAYS-1:0]                      way_hit,
    output logic                                     hit,
    output logic [`DC_DATA_WIDTH-1:0]                load_data,
    output logic [`DC_LINE_WIDTH-1:0]                victim_line,
    output logic                                     victim_valid,
    output logic                                     victim_dirty
);

    import dcache_pkg::*;

    logic [`DC_WORDS-1:0][`DC_DATA_WIDTH-1:0] way0_words;
    logic [`DC_WORDS-1:0][`DC_DATA_WIDTH-1:0] way1_words;

    // Tag compare against the physical address.
    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            way_hit[w] = rvalid[w] && (rtag[w] == pa.fields.tag);
        end
    end

    assign hit = |way_hit;

    assign way0_words = rline[0];
    assign way1_words = rline[1];

    always_comb begin
        case (way_hit)
            2'b01: begin
                load_data = way0_words[pa.fields.word_sel];
            end
            2'b10: begin
                load_data = way1_words[pa.fields.word_sel];
            end
            default: begin
                load_data = way0_words[0];
            end
        endcase
    end

    // Victim follows the way picked for replacement, not the hit way.
    assign victim_line  = rline[select_way];
    assign victim_valid = rvalid[select_way];
    assign victim_dirty = rdirty[select_way];

endmodule

`default_nettype wire

//--- design/dcache_write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_write_ctrl (
    input  logic [`DC_OP_WIDTH-1:0]                                op,
    input  dcache_pkg::cache_addr_u                                ad,
    input  logic [`DC_BYTE_LANES-1:0]                              byte_en,
    input  logic [`DC_DATA_WIDTH-1:0]                              store_data,
    input  logic [`DC_LINE_WIDTH-1:0]                              refill_data,
    input  logic                                                   select_way,
    input  logic [`DC_WAYS-1:0]                                    way_hit,
    output logic [`DC_WAYS-1:0][`DC_WORDS-1:0][`DC_BYTE_LANES-1:0] word_we,
    output logic [`DC_LINE_WIDTH-1:0]                              line_wdata,
    output logic [`DC_WAYS-1:0]                                    tag_we,
    output logic [`DC_WAYS-1:0]                                    valid_we,
    output logic [`DC_WAYS-1:0]                                    dirty_we,
    output logic [`DC_TAG_WIDTH-1:0]                               tag_wdata,
    output logic                                                   valid_wdata,
    output logic                                                   dirty_wdata
);

    import dcache_pkg::*;

    logic store_way;
    logic is_refill;

    assign store_way = way_hit[1];
    assign is_refill = (op == `DC_OP_REFILL);

    // Store word is copied to every word slot; lane enables pick the target.
    assign line_wdata  = is_refill ? refill_data : {`DC_WORDS{store_data}};
    assign tag_wdata   = ad.fields.tag;
    assign valid_wdata = 1'b1;
    assign dirty_wdata = (op == `DC_OP_STORE);

    always_comb begin
        word_we  = '0;
        tag_we   = '0;
        valid_we = '0;
        dirty_we = '0;
        case (op)
            `DC_OP_STORE: begin
                // Missing store writes nothing.
                if (|way_hit) begin
                    word_we[store_way][ad.fields.word_sel] = byte_en;
                    dirty_we[store_way] = 1'b1;
                end
            end
            `DC_OP_REFILL: begin
                word_we[select_way]  = '1;
                tag_we[select_way]   = 1'b1;
                valid_we[select_way] = 1'b1;
                dirty_we[select_way] = 1'b1;
            end
            default: begin
                // Load and idle.
                word_we  = '0;
                tag_we   = '0;
                valid_we = '0;
                dirty_we = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/dcache_way.sv
`timescale 1ns/1ns
`default_nettype none

`include "dcache_consts.svh"

module dcache_way (
    input  logic                                     clk,
    input  logic                                     rst,
    input  dcache_pkg::cache_addr_u                  raddr,
    input  dcache_pkg::cache_addr_u                  waddr,
    input  logic [`DC_WORDS-1:0][`DC_BYTE_LANES-1:0] word_we,
    input  logic [`DC_LINE_WIDTH-1:0]                wdata,
    input  logic                                     tag_we,
    input  logic [`DC_TAG_WIDTH-1:0]                 tag_wdata,
    input  logic                                     valid_we,
    input  logic                                     valid_wdata,
    input  logic                                     dirty_we,
    input  logic                                     dirty_wdata,
    output logic [`DC_LINE_WIDTH-1:0]                rline,
    output logic [`DC_TAG_WIDTH-1:0]                 rtag,
    output logic                                     rvalid,
    output logic                                     rdirty
);

    import dcache_pkg::*;

    logic [`DC_INDEX_WIDTH-1:0] rindex;
    logic [`DC_INDEX_WIDTH-1:0] windex;

    assign rindex = raddr.fields.index;
    assign windex = waddr.fields.index;

    // One memory per word, word 0 in the low bits of the line.
    for (genvar k = 0; k < `DC_WORDS; k++) begin : g_word
        dcache_ram #(
            .WIDTH (`DC_DATA_WIDTH),
            .DEPTH (`DC_SETS),
            .LANES (`DC_BYTE_LANES),
            .CLEAR (1'b0)
        ) u_data (
            .clk   (clk),
            .rst   (rst),
            .we    (word_we[k]),
            .waddr (windex),
            .wdata (wdata[k*`DC_DATA_WIDTH +: `DC_DATA_WIDTH]),
            .raddr (rindex),
            .rdata (rline[k*`DC_DATA_WIDTH +: `DC_DATA_WIDTH])
        );
    end

    dcache_ram #(
        .WIDTH (`DC_TAG_WIDTH),
        .DEPTH (`DC_SETS),
        .LANES (1),
        .CLEAR (1'b0)
    ) u_tag (
        .clk   (clk),
        .rst   (rst),
        .we    (tag_we),
        .waddr (windex),
        .wdata (tag_wdata),
        .raddr (rindex),
        .rdata (rtag)
    );

    // Status bits come up cleared.
    dcache_ram #(
        .WIDTH (1),
        .DEPTH (`DC_SETS),
        .LANES (1),
        .CLEAR (1'b1)
    ) u_valid (
        .clk   (clk),
        .rst   (rst),
        .we    (valid_we),
        .waddr (windex),
        .wdata (valid_wdata),
        .raddr (rindex),
        .rdata (rvalid)
    );

    dcache_ram #(
        .WIDTH (1),
        .DEPTH (`DC_SETS),
        .LANES (1),
        .CLEAR (1'b1)
    ) u_dirty (
        .clk   (clk),
        .rst   (rst),
        .we    (dirty_we),
        .waddr (windex),
        .wdata (dirty_wdata),
        .raddr (rindex),
        .rdata (rdirty)
    );

endmodule

`default_nettype wire

//--- design/dcache_ram.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_ram #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 128,
    parameter int LANES = 4,
    parameter bit CLEAR = 1'b0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [LANES-1:0]         we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    localparam int LANE_WIDTH = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (CLEAR && rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int l = 0; l < LANES; l++) begin
                if (we[l]) begin
                    mem[waddr][l*LANE_WIDTH +: LANE_WIDTH] <=
                        wdata[l*LANE_WIDTH +: LANE_WIDTH];
                end
            end
        end
    end

    // Registered read returns the contents from before a same-edge write.
    always_ff @(posedge clk) begin
        if (CLEAR && rst) begin
            rdata <= '0;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

//--- design/dcache_pkg.sv
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    // Address split, tag in the upper bits.
    typedef struct packed {
        logic [`DC_TAG_WIDTH-1:0]      tag;
        logic [`DC_INDEX_WIDTH-1:0]    index;
        logic [`DC_WORD_SEL_WIDTH-1:0] word_sel;
        logic [`DC_BYTE_SEL_WIDTH-1:0] byte_sel;
    } cache_addr_fields_t;

    // Same 32 bits seen flat or as fields.
    typedef union packed {
        logic [`DC_ADDR_WIDTH-1:0] flat;
        cache_addr_fields_t        fields;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- design/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Word and address widths.
`define DC_ADDR_WIDTH     32
`define DC_DATA_WIDTH     32
`define DC_BYTE_LANES     4

// Line geometry.
`define DC_WORDS          8
`define DC_WORD_SEL_WIDTH 3
`define DC_BYTE_SEL_WIDTH 2
`define DC_LINE_WIDTH     256

// Set geometry, two ways of 128 sets.
`define DC_INDEX_WIDTH    7
`define DC_SETS           128
`define DC_TAG_WIDTH      20
`define DC_WAYS           2

// Operation codes, held for the whole action cycle.
`define DC_OP_WIDTH       2
`define DC_OP_IDLE        2'd0
`define DC_OP_LOAD        2'd1
`define DC_OP_STORE       2'd2
`define DC_OP_REFILL      2'd3

`endif
